// File: build.f
+incdir+hdl
hdl/corePkg.sv
hdl/hazardIf.sv
hdl/decodeUnit.sv
hdl/stallControl.sv
hdl/regFile.sv
hdl/dataMem.sv
hdl/pipeCore.sv
bench/clockGen.sv
bench/core_assert.sv
bench/tb_core.sv

// File: run.sh
#!/bin/sh
# Compile and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_core -o simCore > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/simCore > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qF "=== FAIL ===" "$SIM_LOG"; then
	exit 1
fi
exit 0

// File: bench/core_stimulus.txt
// Per test: instruction words then FFFFFFFF, then register and value pairs then FFFFFFFF
// Pairs list the expected writebacks in program order, all words in hex
// ALU results: lui r1, ori r2, ori r3, lui r4, addu r5, subu r6
3C011234 340200FF 34030F0F 3C048000 00222821 00433023 FFFFFFFF
01 12340000  02 000000FF  03 00000F0F
04 80000000  05 123400FF  06 FFFFF1F0  FFFFFFFF
// Back to back: ori r7, addu r8, subu r9, ori r10, addu r11
34070005 00E74021 01074823 352A0100 01495821 FFFFFFFF
07 00000005  08 0000000A  09 00000005
0A 00000105  0B 0000010A  FFFFFFFF
// Load then use: ori r12, sw r5, lw r13, addu r14, subu r15
340C0040 AD850004 8D8D0004 01A27021 01CD7823 FFFFFFFF
0C 00000040  0D 123400FF  0E 123401FE
0F 000000FF  FFFFFFFF
// Store then load: ori r16, sw r16, lw r17, lw r18, sw r18, lw r19
34105A5A AD900008 8D910008 8D920004 AD92000C 8D93000C FFFFFFFF
10 00005A5A  11 00005A5A  12 123400FF
13 123400FF  FFFFFFFF
// Register zero: ori r0, addu r20, lui r0, ori r21, subu r22
34001111 0000A021 3C00FFFF 34150007 02A0B023 FFFFFFFF
14 00000000  15 00000007  16 00000007  FFFFFFFF

// File: bench/tb_core.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_defines.svh"

module tb_core;
	import corePkg::*;

	localparam int          STIM_WORDS = 256;
	localparam int          WAIT_LIMIT = 200;
	localparam int          TEST_COUNT = 5;
	localparam logic [31:0] END_MARK = 32'hFFFFFFFF;
	// x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	logic    clk;
	logic    rstN;
	logic    instrValid;
	instrT   instrData;
	logic    creditReturn;
	logic    wbEn;
	regAddrT wbReg;
	wordT    wbData;

	logic [31:0] stim [STIM_WORDS];
	logic [31:0] lfsr;
	// Writebacks seen, oldest first
	regAddrT     gotReg [$];
	wordT        gotWord [$];

	int   sentCount = 0;
	int   returnCount = 0;
	int   gotTotal = 0;
	int   expectTotal = 0;
	int   checks = 0;
	int   errors = 0;
	int   failedTests = 0;
	logic timedOut = 1'b0;

	clockGen clkGen0 (
		.clk(clk),
		.rstN(rstN)
	);

	pipeCore dut0 (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instrData(instrData),
		.creditReturn(creditReturn),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	////////////////////////////////////////
	// Monitor
	////////////////////////////////////////
	// Outputs change on the rising edge, so this reads last cycle's values
	always @(posedge clk) begin
		if (rstN && wbEn) begin
			gotReg.push_back(wbReg);
			gotWord.push_back(wbData);
			gotTotal++;
		end
		if (rstN && creditReturn) begin
			returnCount++;
		end
	end

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////
	function automatic logic [31:0] lfsrNext(logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	// Credits the sender holds right now
	function automatic int creditsHeld();
		return `CORE_QUEUE_DEPTH - sentCount + returnCount;
	endfunction

	function automatic string testName(int t);
		case (t)
			0: return "aluResults";
			1: return "backToBack";
			2: return "loadUse";
			3: return "storeLoad";
			4: return "regZero";
			default: return "credits";
		endcase
	endfunction

	task automatic checkReg(string name, regAddrT expVal, regAddrT actVal);
		checks++;
		if (actVal !== expVal) begin
			errors++;
			$display("Fail %s register expected r%0d actual r%0d", name, expVal, actVal);
		end
	endtask

	task automatic checkWord(string name, wordT expVal, wordT actVal);
		checks++;
		if (actVal !== expVal) begin
			errors++;
			$display("Fail %s data expected %08h actual %08h", name, expVal, actVal);
		end
	endtask

	task automatic checkCount(string name, int expVal, int actVal);
		checks++;
		if (actVal != expVal) begin
			errors++;
			$display("Fail %s count expected %0d actual %0d", name, expVal, actVal);
		end
	endtask

	task automatic waitReset(output logic ok);
		int waited;
		waited = 0;
		while (rstN !== 1'b1 && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		ok = (rstN === 1'b1);
	endtask

	// One word on a falling edge, once a credit is held
	task automatic sendInstr(input instrT word, output logic ok);
		int         waited;
		logic [1:0] pick;
		ok = 1'b0;
		waited = 0;
		while (!ok && waited < WAIT_LIMIT) begin
			@(negedge clk);
			instrValid = 1'b0;
			// Two bits, one step each
			lfsr = lfsrNext(lfsr);
			pick[0] = lfsr[0];
			lfsr = lfsrNext(lfsr);
			pick[1] = lfsr[0];
			// Idle gap one time in four
			if (creditsHeld() > 0 && pick != 2'b00) begin
				instrValid = 1'b1;
				instrData = word;
				sentCount++;
				ok = 1'b1;
			end else begin
				waited++;
			end
		end
	endtask

	task automatic waitWriteback(output logic ok);
		int waited;
		waited = 0;
		while (gotReg.size() == 0 && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		ok = (gotReg.size() != 0);
	endtask

	task automatic reportTest(string name, int errBefore);
		if (timedOut) begin
			failedTests++;
			$display("Test %s stopped by a timeout", name);
		end else if (errors != errBefore) begin
			failedTests++;
			$display("Test %s failed with %0d mismatches", name, errors - errBefore);
		end else begin
			$display("Test %s passed", name);
		end
	endtask

	////////////////////////////////////////
	// Tests
	////////////////////////////////////////
	task automatic runTest(input int t, inout int pos);
		int      errBefore;
		logic    ok;
		regAddrT expReg;
		wordT    expWord;
		errBefore = errors;
		// Instruction words up to the marker
		while (!timedOut && pos < STIM_WORDS && stim[pos] !== END_MARK) begin
			sendInstr(stim[pos], ok);
			if (!ok) begin
				$display("Timeout: no credit came back while sending %s", testName(t));
				timedOut = 1'b1;
			end
			pos++;
		end
		@(negedge clk);
		instrValid = 1'b0;
		pos++;
		// Expected pairs up to the marker
		while (!timedOut && pos + 1 < STIM_WORDS && stim[pos] !== END_MARK) begin
			expReg = regAddrT'(stim[pos]);
			expWord = stim[pos + 1];
			pos += 2;
			expectTotal++;
			waitWriteback(ok);
			if (!ok) begin
				$display("Timeout: writeback of r%0d never came in %s", expReg, testName(t));
				timedOut = 1'b1;
			end else begin
				checkReg(testName(t), expReg, gotReg.pop_front());
				checkWord(testName(t), expWord, gotWord.pop_front());
			end
		end
		pos++;
		reportTest(testName(t), errBefore);
	endtask

	// All credits home, no writeback beyond the expected ones
	task automatic checkCredits();
		int waited;
		int errBefore;
		errBefore = errors;
		waited = 0;
		while (creditsHeld() != `CORE_QUEUE_DEPTH && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		checkCount(testName(TEST_COUNT), `CORE_QUEUE_DEPTH, creditsHeld());
		checkCount(testName(TEST_COUNT), expectTotal, gotTotal);
		reportTest(testName(TEST_COUNT), errBefore);
	endtask

	initial begin
		int   pos;
		logic ok;
		instrValid = 1'b0;
		instrData = '0;
		lfsr = 32'h70be4c4e;
		pos = 0;
		$readmemh("bench/core_stimulus.txt", stim);
		waitReset(ok);
		if (!ok) begin
			$display("Reset was never released");
			timedOut = 1'b1;
		end
		for (int t = 0; t < TEST_COUNT && !timedOut; t++) begin
			runTest(t, pos);
		end
		if (!timedOut) begin
			checkCredits();
		end
		$display("Summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
			TEST_COUNT + 1, failedTests, checks, errors);
		if (errors == 0 && failedTests == 0 && !timedOut) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/core_assert.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_defines.svh"

module core_assert (
	input logic                                     clk,
	input logic                                     rstN,
	input logic                                     instrValid,
	input logic                                     creditReturn,
	input logic                                     stall,
	input logic                                     wbEn,
	input logic [$clog2(`CORE_QUEUE_DEPTH + 1)-1:0] qCount
);

	////////////////////////////////////////
	// Credit channel
	////////////////////////////////////////
	// Queue occupancy bounded by the credits
	queueBound: assert property (@(posedge clk) disable iff (!rstN)
		qCount <= `CORE_QUEUE_DEPTH)
		else $error("input queue holds more than its depth");

	// Sender has no credit while the queue is full
	noSendWhenFull: assert property (@(posedge clk) disable iff (!rstN)
		instrValid |-> qCount != `CORE_QUEUE_DEPTH)
		else $error("instruction sent into a full queue");

	// Word sent into an empty queue earns its credit two cycles on
	creditTiming: assert property (@(posedge clk) disable iff (!rstN)
		($past(instrValid, 2) && $past(qCount, 2) == '0 && !$past(stall)) |-> creditReturn)
		else $error("credit not returned two cycles after entering an empty queue");

	////////////////////////////////////////
	// Pipeline
	////////////////////////////////////////
	// Load-use stall lasts one cycle
	stallOnce: assert property (@(posedge clk) disable iff (!rstN)
		stall |=> !stall)
		else $error("stall held for more than one cycle");

	// Stall bubble reaches writeback three cycles later
	bubbleToWb: assert property (@(posedge clk) disable iff (!rstN)
		$past(stall, 3) |-> !wbEn)
		else $error("stall bubble did not reach the writeback stage");

endmodule

bind pipeCore core_assert coreChk (
	.clk(clk),
	.rstN(rstN),
	.instrValid(instrValid),
	.creditReturn(creditReturn),
	.stall(stall),
	.wbEn(wbEn),
	.qCount(qCount)
);

`default_nettype wire

// File: bench/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic rstN
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Reset for 16 cycles, released away from the rising edge
	initial begin
		rstN = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

// File: hdl/pipeCore.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_defines.svh"

module pipeCore (
	input  logic             clk,
	input  logic             rstN,
	input  logic             instrValid,
	input  corePkg::instrT   instrData,
	output logic             creditReturn,
	output logic             wbEn,
	output corePkg::regAddrT wbReg,
	output corePkg::wordT    wbData
);
	import corePkg::*;

	localparam int QW = $clog2(`CORE_QUEUE_DEPTH);
	localparam int CW = $clog2(`CORE_QUEUE_DEPTH + 1);

	// Credit queue
	instrT         queueMem [`CORE_QUEUE_DEPTH];
	logic [QW-1:0] wrPtr;
	logic [QW-1:0] rdPtr;
	logic [CW-1:0] qCount;
	logic          qPop;
	logic          stall;

	// Decode stage
	instrT   instrD;
	regAddrT rsD;
	regAddrT rtD;
	regAddrT a3D;
	wordT    immD;
	aluOpT   aluOpD;
	logic    useImmD;
	logic    memReadD;
	logic    memWriteD;
	logic    regWriteD;
	wordT    rsValD;
	wordT    rtValD;

	// Execute stage
	instrT   instrE;
	regAddrT rsE;
	regAddrT rtE;
	regAddrT a3E;
	aluOpT   aluOpE;
	logic    useImmE;
	logic    memReadE;
	logic    memWriteE;
	logic    regWriteE;
	wordT    rsValE;
	wordT    rtValE;
	wordT    immE;
	wordT    rsFwdE;
	wordT    rtFwdE;
	wordT    opB;
	wordT    aluRes;

	// Memory stage
	instrT   instrM;
	regAddrT rtM;
	regAddrT a3M;
	logic    memReadM;
	logic    memWriteM;
	logic    regWriteM;
	wordT    aluResM;
	wordT    storeM;
	wordT    storeFwdM;
	wordT    dmRdata;

	function automatic logic [QW-1:0] nextPtr(logic [QW-1:0] p);
		return (p == QW'(`CORE_QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	////////////////////////////////////////
	// Credit queue and decode register
	////////////////////////////////////////
	// Leaves the queue only when decode advances
	assign qPop = (qCount != '0) && !stall;

	always_ff @(posedge clk) begin
		if (instrValid) begin
			queueMem[wrPtr] <= instrData;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			qCount <= '0;
			creditReturn <= 1'b0;
			instrD <= '0;
		end else begin
			if (instrValid) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (qPop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			qCount <= qCount + CW'(instrValid) - CW'(qPop);
			creditReturn <= qPop;
			// Held on stall, bubble when the queue is empty
			if (!stall) begin
				instrD <= qPop ? queueMem[rdPtr] : '0;
			end
		end
	end

	decodeUnit decMain (
		.instr(instrD),
		.rs(rsD),
		.rt(rtD),
		.a3(a3D),
		.imm(immD),
		.aluOp(aluOpD),
		.useImm(useImmD),
		.memRead(memReadD),
		.memWrite(memWriteD),
		.regWrite(regWriteD),
		.tuseRs(), .tuseRt(), .tnew()
	);

	regFile rf0 (
		.clk(clk),
		.rstN(rstN),
		.raddrA(rsD),
		.raddrB(rtD),
		.rdataA(rsValD),
		.rdataB(rtValD),
		.we(wbEn),
		.waddr(wbReg),
		.wdata(wbData)
	);

	// Hazard view of E and M
	hazardIf hz ();

	assign hz.instrE = instrE;
	assign hz.a3E = a3E;
	assign hz.instrM = instrM;
	assign hz.a3M = a3M;

	stallControl stall0 (
		.instrD(instrD),
		.hz(hz.check),
		.stall(stall)
	);

	////////////////////////////////////////
	// Execute
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			instrE <= '0;
			rsE <= '0;
			rtE <= '0;
			a3E <= '0;
			aluOpE <= ALU_ADD;
			useImmE <= 1'b0;
			memReadE <= 1'b0;
			memWriteE <= 1'b0;
			regWriteE <= 1'b0;
		end else begin
			// Stall inserts a bubble
			instrE <= stall ? '0 : instrD;
			rsE <= stall ? '0 : rsD;
			rtE <= stall ? '0 : rtD;
			a3E <= stall ? '0 : a3D;
			aluOpE <= stall ? ALU_ADD : aluOpD;
			useImmE <= !stall && useImmD;
			memReadE <= !stall && memReadD;
			memWriteE <= !stall && memWriteD;
			regWriteE <= !stall && regWriteD;
		end
	end

	always_ff @(posedge clk) begin
		rsValE <= rsValD;
		rtValE <= rtValD;
		immE <= immD;
	end

	// Memory beats writeback, a load in memory has no data yet
	assign rsFwdE = (regWriteM && !memReadM && a3M != '0 && a3M == rsE) ? aluResM :
		(wbEn && wbReg == rsE) ? wbData : rsValE;
	assign rtFwdE = (regWriteM && !memReadM && a3M != '0 && a3M == rtE) ? aluResM :
		(wbEn && wbReg == rtE) ? wbData : rtValE;

	always_comb begin
		opB = useImmE ? immE : rtFwdE;
		unique case (aluOpE)
			ALU_ADD: aluRes = rsFwdE + opB;
			ALU_SUB: aluRes = rsFwdE - opB;
			ALU_OR:  aluRes = rsFwdE | opB;
			ALU_LUI: aluRes = opB;
		endcase
	end

	////////////////////////////////////////
	// Memory and writeback
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			instrM <= '0;
			rtM <= '0;
			a3M <= '0;
			memReadM <= 1'b0;
			memWriteM <= 1'b0;
			regWriteM <= 1'b0;
			wbEn <= 1'b0;
			wbReg <= '0;
		end else begin
			instrM <= instrE;
			rtM <= rtE;
			a3M <= a3E;
			memReadM <= memReadE;
			memWriteM <= memWriteE;
			regWriteM <= regWriteE;
			// r0 writes never show up
			wbEn <= regWriteM && (a3M != '0);
			wbReg <= a3M;
		end
	end

	always_ff @(posedge clk) begin
		aluResM <= aluRes;
		storeM <= rtFwdE;
		wbData <= memReadM ? dmRdata : aluResM;
	end

	// Store data late from a load just retired
	assign storeFwdM = (wbEn && wbReg == rtM) ? wbData : storeM;

	dataMem dm0 (
		.clk(clk),
		.we(memWriteM),
		.addr(aluResM),
		.wdata(storeFwdM),
		.rdata(dmRdata)
	);

endmodule

`default_nettype wire

// File: hdl/dataMem.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_defines.svh"

module dataMem (
	input  logic          clk,
	input  logic          we,
	input  corePkg::wordT addr,
	input  corePkg::wordT wdata,
	output corePkg::wordT rdata
);
	import corePkg::*;

	localparam int AW = $clog2(`CORE_DM_WORDS);

	wordT mem [`CORE_DM_WORDS];

	// Word index, byte offset bits ignored
	logic [AW-1:0] idx;

	assign idx = addr[AW+1:2];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[idx] <= wdata;
		end
	end

	assign rdata = mem[idx];

endmodule

`default_nettype wire

// File: hdl/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
	input  logic             clk,
	input  logic             rstN,
	input  corePkg::regAddrT raddrA,
	input  corePkg::regAddrT raddrB,
	output corePkg::wordT    rdataA,
	output corePkg::wordT    rdataB,
	input  logic             we,
	input  corePkg::regAddrT waddr,
	input  corePkg::wordT    wdata
);
	import corePkg::*;

	wordT regs [32];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// r0 first, then the value being written this cycle
	assign rdataA = (raddrA == '0) ? '0 : (we && waddr == raddrA) ? wdata : regs[raddrA];
	assign rdataB = (raddrB == '0) ? '0 : (we && waddr == raddrB) ? wdata : regs[raddrB];

endmodule

`default_nettype wire

// File: hdl/stallControl.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_defines.svh"

module stallControl (
	input  corePkg::instrT instrD,
	hazardIf.check         hz,
	output logic           stall
);
	import corePkg::*;

	regAddrT    rsD;
	regAddrT    rtD;
	stageT      tuseRsD;
	stageT      tuseRtD;
	stageT      tnewE;
	stageT      tnewMRaw;
	stageT      tnewM;
	logic [7:0] stallCase;

	// Nonzero source matching a producer's destination
	function automatic logic dep(regAddrT src, regAddrT dst);
		return (src != '0) && (src == dst);
	endfunction

	// Operand wanted at stage need, producer not ready by then
	function automatic logic lateFor(stageT tuse, stageT tnewIn, stageT need);
		return (tuse == need) && (tnewIn > need);
	endfunction

	////////////////////////////////////////
	// Decoders for D, E and M
	////////////////////////////////////////
	decodeUnit decD (
		.instr(instrD),
		.rs(rsD),
		.rt(rtD),
		.a3(), .imm(), .aluOp(), .useImm(),
		.memRead(), .memWrite(), .regWrite(),
		.tuseRs(tuseRsD),
		.tuseRt(tuseRtD),
		.tnew()
	);

	decodeUnit decE (
		.instr(hz.instrE),
		.rs(), .rt(), .a3(), .imm(), .aluOp(), .useImm(),
		.memRead(), .memWrite(), .regWrite(),
		.tuseRs(), .tuseRt(),
		.tnew(tnewE)
	);

	decodeUnit decM (
		.instr(hz.instrM),
		.rs(), .rt(), .a3(), .imm(), .aluOp(), .useImm(),
		.memRead(), .memWrite(), .regWrite(),
		.tuseRs(), .tuseRt(),
		.tnew(tnewMRaw)
	);

	// One stage already spent in memory
	assign tnewM = (tnewMRaw == '0) ? '0 : tnewMRaw - 2'd1;

	////////////////////////////////////////
	// Tuse against Tnew
	////////////////////////////////////////
	always_comb begin
		// rs against execute and memory
		stallCase[0] = dep(rsD, hz.a3E) && lateFor(tuseRsD, tnewE, `CORE_TUSE_E);
		stallCase[1] = dep(rsD, hz.a3E) && lateFor(tuseRsD, tnewE, `CORE_TUSE_M);
		stallCase[2] = dep(rsD, hz.a3M) && lateFor(tuseRsD, tnewM, `CORE_TUSE_E);
		stallCase[3] = dep(rsD, hz.a3M) && lateFor(tuseRsD, tnewM, `CORE_TUSE_M);
		// rt likewise
		stallCase[4] = dep(rtD, hz.a3E) && lateFor(tuseRtD, tnewE, `CORE_TUSE_E);
		stallCase[5] = dep(rtD, hz.a3E) && lateFor(tuseRtD, tnewE, `CORE_TUSE_M);
		stallCase[6] = dep(rtD, hz.a3M) && lateFor(tuseRtD, tnewM, `CORE_TUSE_E);
		stallCase[7] = dep(rtD, hz.a3M) && lateFor(tuseRtD, tnewM, `CORE_TUSE_M);
	end

	assign stall = |stallCase;

endmodule

`default_nettype wire

// File: hdl/decodeUnit.sv
`timescale 1ns/10ps
`default_nettype none
`include "core_defines.svh"

module decodeUnit (
	input  corePkg::instrT   instr,
	output corePkg::regAddrT rs,
	output corePkg::regAddrT rt,
	output corePkg::regAddrT a3,
	output corePkg::wordT    imm,
	output corePkg::aluOpT   aluOp,
	output logic             useImm,
	output logic             memRead,
	output logic             memWrite,
	output logic             regWrite,
	output corePkg::stageT   tuseRs,
	output corePkg::stageT   tuseRt,
	output corePkg::stageT   tnew
);
	import corePkg::*;

	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic [15:0] imm16;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign imm16 = instr[15:0];

	always_comb begin
		// Defaults give a no-op, so a bubble writes nothing
		rs = '0;
		rt = '0;
		a3 = '0;
		imm = '0;
		aluOp = ALU_ADD;
		useImm = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		regWrite = 1'b0;
		tuseRs = '0;
		tuseRt = '0;
		tnew = '0;
		case (opcode)
			`CORE_OP_RTYPE: begin
				// Only addu and subu, other funct codes stay no-ops
				if (funct == `CORE_FN_ADDU || funct == `CORE_FN_SUBU) begin
					rs = instr[25:21];
					rt = instr[20:16];
					a3 = instr[15:11];
					aluOp = (funct == `CORE_FN_SUBU) ? ALU_SUB : ALU_ADD;
					regWrite = 1'b1;
					tuseRs = `CORE_TUSE_E;
					tuseRt = `CORE_TUSE_E;
					tnew = `CORE_T_ALU;
				end
			end
			`CORE_OP_ORI: begin
				rs = instr[25:21];
				a3 = instr[20:16];
				// Zero extended
				imm = {16'h0000, imm16};
				aluOp = ALU_OR;
				useImm = 1'b1;
				regWrite = 1'b1;
				tuseRs = `CORE_TUSE_E;
				tnew = `CORE_T_ALU;
			end
			`CORE_OP_LUI: begin
				// No source operand at all
				a3 = instr[20:16];
				imm = {imm16, 16'h0000};
				aluOp = ALU_LUI;
				useImm = 1'b1;
				regWrite = 1'b1;
				tnew = `CORE_T_ALU;
			end
			`CORE_OP_LW: begin
				rs = instr[25:21];
				a3 = instr[20:16];
				imm = {{16{imm16[15]}}, imm16};
				useImm = 1'b1;
				memRead = 1'b1;
				regWrite = 1'b1;
				tuseRs = `CORE_TUSE_E;
				tnew = `CORE_T_DM;
			end
			`CORE_OP_SW: begin
				rs = instr[25:21];
				rt = instr[20:16];
				imm = {{16{imm16[15]}}, imm16};
				useImm = 1'b1;
				memWrite = 1'b1;
				tuseRs = `CORE_TUSE_E;
				// Store data only needed in memory
				tuseRt = `CORE_TUSE_M;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/hazardIf.sv
`timescale 1ns/10ps
`default_nettype none

interface hazardIf;
	import corePkg::*;

	// Producer sitting in execute
	instrT   instrE;
	regAddrT a3E;

	// Producer sitting in memory
	instrT   instrM;
	regAddrT a3M;

	// Pipeline side
	modport stage (output instrE, a3E, instrM, a3M);

	// Stall controller side
	modport check (input instrE, a3E, instrM, a3M);

endinterface

`default_nettype wire

// File: hdl/corePkg.sv
`default_nettype none

package corePkg;

	////////////////////////////////////////
	// Data path words
	////////////////////////////////////////
	typedef logic [31:0] wordT;
	typedef logic [31:0] instrT;

	// Register number, r0 hardwired to zero
	typedef logic [4:0] regAddrT;

	// Stage count for Tuse and Tnew
	// 0 ready or unused, 1 one stage on, 2 two stages on
	typedef logic [1:0] stageT;

	////////////////////////////////////////
	// ALU operations
	////////////////////////////////////////
	typedef enum logic [1:0] {
		ALU_ADD = 2'd0,
		ALU_SUB = 2'd1,
		ALU_OR  = 2'd2,
		// Passes the shifted immediate
		ALU_LUI = 2'd3
	} aluOpT;

endpackage

`default_nettype wire

// File: hdl/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

////////////////////////////////////////
// Opcode and funct codes
////////////////////////////////////////
`define CORE_OP_RTYPE 6'h00
`define CORE_OP_ORI   6'h0d
`define CORE_OP_LUI   6'h0f
`define CORE_OP_LW    6'h23
`define CORE_OP_SW    6'h2b
`define CORE_FN_ADDU  6'h21
`define CORE_FN_SUBU  6'h23

////////////////////////////////////////
// Stage counts
////////////////////////////////////////
// Tuse, operand wanted in execute or in memory
`define CORE_TUSE_E 2'd1
`define CORE_TUSE_M 2'd2
// Tnew seen from execute
`define CORE_T_ALU  2'd1
`define CORE_T_DM   2'd2

// Input queue slots, also the sender's starting credits
`define CORE_QUEUE_DEPTH 2
`define CORE_DM_WORDS    64

`endif
